// File: dma_cfg_pkg.sv
package dma_cfg_pkg;

  // Datapath widths
  localparam int DATA_W = 32;
  localparam int ADDR_W = 32;

  // Channels per side, ingress and egress alike
  localparam int NUM_CH = 2;

  // One block fills the whole buffer
  localparam int BLOCK_WORDS = 16;
  localparam int BUF_AW      = 4;
  localparam int CNT_W       = 5;

  // Byte stride of one data word
  localparam int WORD_BYTES = 4;

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [BUF_AW-1:0] buf_addr_t;
  typedef logic [CNT_W-1:0]  count_t;

endpackage

// File: seq_pkg.sv
package seq_pkg;

  // Transfer sequencer states
  typedef enum logic [3:0] {
    IDLE,
    SELECT,
    ING_FILL,
    ING_WRITE,
    ING_WAIT,
    ING_DONE,
    EGR_READ,
    EGR_WAIT,
    EGR_DRAIN
  } seq_state_t;

  // Which side owns the buffer
  typedef enum logic {
    SIDE_ING,
    SIDE_EGR
  } side_t;

endpackage

// File: dma_ifs.sv
// Grant state from the sequencer, channel view from the arbiter
interface grant_if;
  import dma_cfg_pkg::*;

  logic                      side;
  logic [$clog2(NUM_CH)-1:0] sel;
  logic                      path_en;
  logic                      finished;
  logic                      req_ing;
  logic                      req_egr;
  logic                      pick_side;
  logic [$clog2(NUM_CH)-1:0] pick_sel;
  addr_t                     ch_addr;
  logic                      ch_enable;

  modport sequencer (output side, sel, path_en, finished,
                     input  req_ing, req_egr, pick_side, pick_sel, ch_addr, ch_enable);
  modport arbiter   (input  side, sel, path_en, finished,
                     output req_ing, req_egr, pick_side, pick_sel, ch_addr, ch_enable);
  modport buffer    (input  side);
endinterface

// Word streams between the granted channel and the buffer
interface stream_if;
  import dma_cfg_pkg::*;

  logic  wr_stb;
  logic  wr_ready;
  data_t wr_data;
  logic  rd_stb;
  logic  rd_ready;
  data_t rd_data;

  modport source (output wr_stb, wr_data, rd_stb, input wr_ready, rd_ready, rd_data);
  modport sink   (input wr_stb, wr_data, rd_stb, output wr_ready, rd_ready, rd_data);
endinterface

interface buf_ctrl_if;
  import dma_cfg_pkg::*;

  logic   clear;
  logic   fill_en;
  logic   drain_start;
  count_t level;
  logic   full;
  logic   drained;

  modport sequencer (output clear, fill_en, drain_start, input level, full, drained);
  modport buffer    (input clear, fill_en, drain_start, output level, full, drained);
endinterface

// File: dma_arbiter.sv
module dma_arbiter (
  input  logic                              clk,
  input  logic                              rst,
  input  logic [dma_cfg_pkg::NUM_CH-1:0]    i_ing_enable,
  input  dma_cfg_pkg::addr_t                i_ing_addr [dma_cfg_pkg::NUM_CH],
  input  logic [dma_cfg_pkg::NUM_CH-1:0]    i_ing_stb,
  input  dma_cfg_pkg::data_t                i_ing_data [dma_cfg_pkg::NUM_CH],
  output logic [dma_cfg_pkg::NUM_CH-1:0]    o_ing_ready,
  output logic [dma_cfg_pkg::NUM_CH-1:0]    o_ing_finished,
  input  logic [dma_cfg_pkg::NUM_CH-1:0]    i_egr_enable,
  input  dma_cfg_pkg::addr_t                i_egr_addr [dma_cfg_pkg::NUM_CH],
  input  logic [dma_cfg_pkg::NUM_CH-1:0]    i_egr_stb,
  output logic [dma_cfg_pkg::NUM_CH-1:0]    o_egr_ready,
  output dma_cfg_pkg::data_t                o_egr_data [dma_cfg_pkg::NUM_CH],
  grant_if.arbiter                          gnt,
  stream_if.source                          strm
);
  import dma_cfg_pkg::*;
  import seq_pkg::*;

  side_t                     r_side_rr;
  logic [$clog2(NUM_CH)-1:0] r_ch_rr [2];
  logic                      r_path_en_q;
  side_t                     w_pick_side;
  logic [NUM_CH-1:0]         w_side_en;
  logic [$clog2(NUM_CH)-1:0] w_idx;
  logic [NUM_CH-1:0]         w_hit;
  logic                      w_ing_act;
  logic                      w_egr_act;

  assign gnt.req_ing = |i_ing_enable;
  assign gnt.req_egr = |i_egr_enable;

  // Side choice offered to the sequencer in IDLE
  always_comb begin
    if (gnt.req_ing && gnt.req_egr) begin
      w_pick_side = r_side_rr;
    end else if (gnt.req_egr) begin
      w_pick_side = SIDE_EGR;
    end else begin
      w_pick_side = SIDE_ING;
    end
  end
  assign gnt.pick_side = w_pick_side;

  // Channel choice within the side latched by the sequencer
  assign w_side_en = (gnt.side == SIDE_EGR) ? i_egr_enable : i_ing_enable;
  assign gnt.pick_sel = (&w_side_en) ? r_ch_rr[gnt.side] : !w_side_en[0];

  // Before the grant the candidate channel is shown so its address can be latched
  assign w_idx         = gnt.path_en ? gnt.sel : gnt.pick_sel;
  assign gnt.ch_addr   = (gnt.side == SIDE_EGR) ? i_egr_addr[w_idx] : i_ing_addr[w_idx];
  assign gnt.ch_enable = w_side_en[w_idx];

  assign w_ing_act = gnt.path_en && (gnt.side == SIDE_ING);
  assign w_egr_act = gnt.path_en && (gnt.side == SIDE_EGR);
  assign w_hit     = (NUM_CH)'(1) << gnt.sel;

  // Shared paths toward the buffer
  assign strm.wr_stb  = w_ing_act && i_ing_stb[gnt.sel];
  assign strm.wr_data = i_ing_data[gnt.sel];
  assign strm.rd_stb  = w_egr_act && i_egr_stb[gnt.sel];

  // Fan back to the granted channel only
  assign o_ing_ready    = w_hit & {NUM_CH{w_ing_act && strm.wr_ready}};
  assign o_ing_finished = w_hit & {NUM_CH{w_ing_act && gnt.finished}};
  assign o_egr_ready    = w_hit & {NUM_CH{w_egr_act && strm.rd_ready}};

  always_comb begin
    for (int c = 0; c < NUM_CH; c++) begin
      o_egr_data[c] = (w_egr_act && w_hit[c]) ? strm.rd_data : '0;
    end
  end

  // Round-robin bits move on the first cycle of a grant
  always_ff @(posedge clk) begin
    if (rst) begin
      r_path_en_q <= 1'b0;
      r_side_rr   <= SIDE_ING;
      r_ch_rr[0]  <= '0;
      r_ch_rr[1]  <= '0;
    end else begin
      r_path_en_q <= gnt.path_en;
      if (gnt.path_en && !r_path_en_q) begin
        r_side_rr         <= (gnt.side == SIDE_ING) ? SIDE_EGR : SIDE_ING;
        r_ch_rr[gnt.side] <= ~gnt.sel;
      end
    end
  end

endmodule

// File: block_buffer.sv
module block_buffer (
  input  logic                   clk,
  input  logic                   rst,
  grant_if.buffer                gnt,
  stream_if.sink                 strm,
  buf_ctrl_if.buffer             ctrl,
  input  dma_cfg_pkg::buf_addr_t i_buf_addr,
  input  logic                   i_buf_we,
  input  dma_cfg_pkg::data_t     i_buf_din,
  output dma_cfg_pkg::data_t     o_buf_dout
);
  import dma_cfg_pkg::*;
  import seq_pkg::*;

  data_t     r_mem [BLOCK_WORDS];
  count_t    r_fill_cnt;
  buf_addr_t r_drain_cnt;
  logic      r_draining;
  logic      r_drained;
  logic      w_full;
  logic      w_fill_take;
  logic      w_drain_take;

  assign w_full = (r_fill_cnt == count_t'(BLOCK_WORDS));

  assign ctrl.level   = r_fill_cnt;
  assign ctrl.full    = w_full;
  assign ctrl.drained = r_drained;

  // Each stream only opens for its own side
  assign strm.wr_ready = ctrl.fill_en && !w_full && (gnt.side == SIDE_ING);
  assign strm.rd_ready = r_draining && (gnt.side == SIDE_EGR);
  assign strm.rd_data  = r_mem[r_drain_cnt];

  assign w_fill_take  = strm.wr_stb && strm.wr_ready;
  assign w_drain_take = strm.rd_stb && strm.rd_ready;

  // Memory port writes only while egress waits, fill only while ingress fills
  always_ff @(posedge clk) begin
    if (i_buf_we) begin
      r_mem[i_buf_addr] <= i_buf_din;
    end else if (w_fill_take) begin
      r_mem[r_fill_cnt[BUF_AW-1:0]] <= strm.wr_data;
    end
    o_buf_dout <= r_mem[i_buf_addr];
  end

  // Fill counter doubles as the level seen by the sequencer
  always_ff @(posedge clk) begin
    if (rst) begin
      r_fill_cnt <= '0;
    end else if (ctrl.clear) begin
      r_fill_cnt <= '0;
    end else if (w_fill_take) begin
      r_fill_cnt <= r_fill_cnt + 1'b1;
    end
  end

  // Drain walks the whole block once per start
  always_ff @(posedge clk) begin
    if (rst) begin
      r_drain_cnt <= '0;
      r_draining  <= 1'b0;
      r_drained   <= 1'b0;
    end else if (ctrl.clear) begin
      r_drain_cnt <= '0;
      r_draining  <= 1'b0;
      r_drained   <= 1'b0;
    end else if (ctrl.drain_start) begin
      r_drain_cnt <= '0;
      r_draining  <= 1'b1;
      r_drained   <= 1'b0;
    end else if (w_drain_take) begin
      r_drain_cnt <= r_drain_cnt + 1'b1;
      // Last word of the block
      if (r_drain_cnt == buf_addr_t'(BLOCK_WORDS - 1)) begin
        r_draining <= 1'b0;
        r_drained  <= 1'b1;
      end
    end
  end

endmodule

// File: transfer_sequencer.sv
module transfer_sequencer (
  input  logic                clk,
  input  logic                rst,
  grant_if.sequencer          gnt,
  buf_ctrl_if.sequencer       ctrl,
  output logic                o_mem_wr_go,
  output logic                o_mem_rd_go,
  output dma_cfg_pkg::addr_t  o_mem_addr,
  output dma_cfg_pkg::count_t o_mem_count,
  input  logic                i_mem_busy
);
  import dma_cfg_pkg::*;
  import seq_pkg::*;

  seq_state_t                r_state;
  side_t                     r_side;
  logic [$clog2(NUM_CH)-1:0] r_sel;
  logic                      r_path_en;
  logic                      r_busy_seen;
  addr_t                     r_addr;
  count_t                    r_count;
  logic                      w_cmd_done;

  // Command retires when busy falls after having risen
  assign w_cmd_done = r_busy_seen && !i_mem_busy;

  assign gnt.side     = r_side;
  assign gnt.sel      = r_sel;
  assign gnt.path_en  = r_path_en;
  assign gnt.finished = (r_state == ING_DONE);

  // Buffer restarts at grant and after each written block
  assign ctrl.clear       = (r_state == SELECT) || ((r_state == ING_WAIT) && w_cmd_done);
  assign ctrl.fill_en     = (r_state == ING_FILL) && gnt.ch_enable;
  assign ctrl.drain_start = (r_state == EGR_WAIT) && w_cmd_done;

  assign o_mem_wr_go = (r_state == ING_WRITE);
  assign o_mem_rd_go = (r_state == EGR_READ);
  assign o_mem_addr  = r_addr;
  assign o_mem_count = r_count;

  // Busy may already be up in the go cycle itself
  always_ff @(posedge clk) begin
    if (rst) begin
      r_busy_seen <= 1'b0;
    end else if (i_mem_busy) begin
      r_busy_seen <= 1'b1;
    end else if (o_mem_wr_go || o_mem_rd_go) begin
      r_busy_seen <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      r_state   <= IDLE;
      r_side    <= SIDE_ING;
      r_sel     <= '0;
      r_path_en <= 1'b0;
    end else begin
      case (r_state)
        IDLE: begin
          if (gnt.req_ing || gnt.req_egr) begin
            r_side  <= side_t'(gnt.pick_side);
            r_state <= SELECT;
          end
        end
        SELECT: begin
          r_sel     <= gnt.pick_sel;
          r_path_en <= 1'b1;
          r_state   <= (r_side == SIDE_ING) ? ING_FILL : EGR_READ;
        end
        ING_FILL: begin
          // Full block, or a partial one left behind by the channel
          if (ctrl.full || (!gnt.ch_enable && (ctrl.level != '0))) begin
            r_state <= ING_WRITE;
          end else if (!gnt.ch_enable) begin
            r_state <= ING_DONE;
          end
        end
        ING_WRITE: r_state <= ING_WAIT;
        ING_WAIT: begin
          if (w_cmd_done) begin
            r_state <= ING_FILL;
          end
        end
        ING_DONE: begin
          r_path_en <= 1'b0;
          r_state   <= IDLE;
        end
        EGR_READ: r_state <= EGR_WAIT;
        EGR_WAIT: begin
          if (w_cmd_done) begin
            r_state <= EGR_DRAIN;
          end
        end
        EGR_DRAIN: begin
          // Another round only while the channel still wants data
          if (ctrl.drained) begin
            r_path_en <= gnt.ch_enable;
            r_state   <= gnt.ch_enable ? EGR_READ : IDLE;
          end
        end
        default: begin
          r_path_en <= 1'b0;
          r_state   <= IDLE;
        end
      endcase
    end
  end

  // Address and count of the current command
  always_ff @(posedge clk) begin
    if (r_state == SELECT) begin
      r_addr  <= gnt.ch_addr;
      r_count <= count_t'(BLOCK_WORDS);
    end else if (r_state == ING_FILL) begin
      r_count <= ctrl.level;
    end else if (((r_state == ING_WAIT) || (r_state == EGR_WAIT)) && w_cmd_done) begin
      r_addr <= r_addr + addr_t'(r_count) * addr_t'(WORD_BYTES);
    end
  end

endmodule

// File: ddr_arbiter_top.sv
module ddr_arbiter_top (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [dma_cfg_pkg::NUM_CH-1:0] i_ing_enable,
  input  dma_cfg_pkg::addr_t             i_ing_addr [dma_cfg_pkg::NUM_CH],
  input  logic [dma_cfg_pkg::NUM_CH-1:0] i_ing_stb,
  input  dma_cfg_pkg::data_t             i_ing_data [dma_cfg_pkg::NUM_CH],
  output logic [dma_cfg_pkg::NUM_CH-1:0] o_ing_ready,
  output logic [dma_cfg_pkg::NUM_CH-1:0] o_ing_finished,
  input  logic [dma_cfg_pkg::NUM_CH-1:0] i_egr_enable,
  input  dma_cfg_pkg::addr_t             i_egr_addr [dma_cfg_pkg::NUM_CH],
  input  logic [dma_cfg_pkg::NUM_CH-1:0] i_egr_stb,
  output logic [dma_cfg_pkg::NUM_CH-1:0] o_egr_ready,
  output dma_cfg_pkg::data_t             o_egr_data [dma_cfg_pkg::NUM_CH],
  output logic                           o_mem_wr_go,
  output logic                           o_mem_rd_go,
  output dma_cfg_pkg::addr_t             o_mem_addr,
  output dma_cfg_pkg::count_t            o_mem_count,
  input  logic                           i_mem_busy,
  input  dma_cfg_pkg::buf_addr_t         i_buf_addr,
  input  logic                           i_buf_we,
  input  dma_cfg_pkg::data_t             i_buf_din,
  output dma_cfg_pkg::data_t             o_buf_dout
);

  grant_if    grant ();
  stream_if   stream ();
  buf_ctrl_if buf_ctrl ();

  // Channel side
  dma_arbiter i_dma_arbiter (
    .clk            (clk),
    .rst            (rst),
    .i_ing_enable   (i_ing_enable),
    .i_ing_addr     (i_ing_addr),
    .i_ing_stb      (i_ing_stb),
    .i_ing_data     (i_ing_data),
    .o_ing_ready    (o_ing_ready),
    .o_ing_finished (o_ing_finished),
    .i_egr_enable   (i_egr_enable),
    .i_egr_addr     (i_egr_addr),
    .i_egr_stb      (i_egr_stb),
    .o_egr_ready    (o_egr_ready),
    .o_egr_data     (o_egr_data),
    .gnt            (grant.arbiter),
    .strm           (stream.source)
  );

  block_buffer i_block_buffer (
    .clk        (clk),
    .rst        (rst),
    .gnt        (grant.buffer),
    .strm       (stream.sink),
    .ctrl       (buf_ctrl.buffer),
    .i_buf_addr (i_buf_addr),
    .i_buf_we   (i_buf_we),
    .i_buf_din  (i_buf_din),
    .o_buf_dout (o_buf_dout)
  );

  // Memory command side
  transfer_sequencer i_transfer_sequencer (
    .clk         (clk),
    .rst         (rst),
    .gnt         (grant.sequencer),
    .ctrl        (buf_ctrl.sequencer),
    .o_mem_wr_go (o_mem_wr_go),
    .o_mem_rd_go (o_mem_rd_go),
    .o_mem_addr  (o_mem_addr),
    .o_mem_count (o_mem_count),
    .i_mem_busy  (i_mem_busy)
  );

endmodule

// File: tb_ddr_arbiter_assert.sv
module tb_ddr_arbiter_assert (
  input logic                           clk,
  input logic                           rst,
  input logic                           o_mem_wr_go,
  input logic                           o_mem_rd_go,
  input dma_cfg_pkg::addr_t             o_mem_addr,
  input logic                           i_mem_busy,
  input logic [dma_cfg_pkg::NUM_CH-1:0] o_ing_ready,
  input logic [dma_cfg_pkg::NUM_CH-1:0] o_egr_ready
);
  timeunit 1ns;
  timeprecision 100ps;

  // Go pulses last a single cycle
  assert property (@(posedge clk) disable iff (rst) o_mem_wr_go |=> !o_mem_wr_go)
    else $error("write go longer than one cycle");
  assert property (@(posedge clk) disable iff (rst) o_mem_rd_go |=> !o_mem_rd_go)
    else $error("read go longer than one cycle");

  assert property (@(posedge clk) disable iff (rst) !(o_mem_wr_go && o_mem_rd_go))
    else $error("write and read go together");

  assert property (@(posedge clk) disable iff (rst) $onehot0(o_ing_ready) && $onehot0(o_egr_ready))
    else $error("more than one channel ready on a side");

  assert property (@(posedge clk) disable iff (rst)
                   (i_mem_busy && $past(i_mem_busy)) |-> $stable(o_mem_addr))
    else $error("memory address moved while busy");

endmodule

bind ddr_arbiter_top tb_ddr_arbiter_assert i_tb_ddr_arbiter_assert (.*);

// File: tb_ddr_arbiter.sv
module tb_ddr_arbiter;
  timeunit 1ns;
  timeprecision 100ps;

  import dma_cfg_pkg::*;
  import seq_pkg::*;

  localparam logic [31:0] PATTERN        = 32'h5a5a0000;
  localparam int          TIMEOUT_CYCLES = 6000;
  localparam int          WAIT_LIMIT     = 400;

  logic               clk;
  logic               rst;
  logic [NUM_CH-1:0]  i_ing_enable;
  addr_t              i_ing_addr [NUM_CH];
  logic [NUM_CH-1:0]  i_ing_stb;
  data_t              i_ing_data [NUM_CH];
  logic [NUM_CH-1:0]  o_ing_ready;
  logic [NUM_CH-1:0]  o_ing_finished;
  logic [NUM_CH-1:0]  i_egr_enable;
  addr_t              i_egr_addr [NUM_CH];
  logic [NUM_CH-1:0]  i_egr_stb;
  logic [NUM_CH-1:0]  o_egr_ready;
  data_t              o_egr_data [NUM_CH];
  logic               o_mem_wr_go;
  logic               o_mem_rd_go;
  addr_t              o_mem_addr;
  count_t             o_mem_count;
  logic               i_mem_busy;
  buf_addr_t          i_buf_addr;
  logic               i_buf_we;
  data_t              i_buf_din;
  data_t              o_buf_dout;

  // Memory model contents, expected words and command log
  data_t       store_mem [addr_t];
  data_t       exp_mem [addr_t];
  addr_t       cmd_addr_q [$];
  int          cmd_cnt_q [$];
  logic        cmd_wr_q [$];
  int          fin_count [NUM_CH];
  logic        ready_seen [NUM_CH];
  logic [31:0] lfsr_state;
  int          errors;
  int          checks;
  int          tests_run;
  int          cycle_count;

  ddr_arbiter_top i_ddr_arbiter_top (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // One step of the Galois LFSR per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int b = 0; b < n; b++) begin
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("FAILED %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic report_error(input string msg);
    $display("Error: %s", msg);
    errors++;
  endtask

  task automatic check_command(input int idx, input logic wr, input addr_t addr,
                               input int cnt);
    if (idx >= cmd_addr_q.size()) begin
      report_error("expected memory command never issued");
    end else begin
      check_value("o_mem_addr", cmd_addr_q[idx], addr);
      check_value("o_mem_count", 32'(cmd_cnt_q[idx]), 32'(cnt));
      check_value("o_mem_wr_go", 32'(cmd_wr_q[idx]), 32'(wr));
    end
  endtask

  task automatic check_stored(input addr_t base, input int n);
    addr_t a;
    for (int i = 0; i < n; i++) begin
      a = base + addr_t'(4 * i);
      if (!store_mem.exists(a)) begin
        report_error("word missing from memory model");
      end else begin
        check_value("stored word", store_mem[a], exp_mem[a]);
      end
    end
  endtask

  // Memory controller model on the command and buffer ports
  initial begin : mem_model
    addr_t base;
    int    cnt;
    logic  is_wr;
    forever begin
      @(posedge clk);
      #1;
      if (!rst && (o_mem_wr_go || o_mem_rd_go)) begin
        base  = o_mem_addr;
        cnt   = int'(o_mem_count);
        is_wr = o_mem_wr_go;
        cmd_addr_q.push_back(base);
        cmd_cnt_q.push_back(cnt);
        cmd_wr_q.push_back(is_wr);
        i_mem_busy = 1'b1;
        for (int i = 0; i < cnt; i++) begin
          i_buf_addr = buf_addr_t'(i);
          if (!is_wr) begin
            i_buf_we  = 1'b1;
            i_buf_din = (base + addr_t'(4 * i)) ^ PATTERN;
          end
          @(posedge clk);
          #1;
          if (is_wr) store_mem[base + addr_t'(4 * i)] = o_buf_dout;
        end
        i_buf_we   = 1'b0;
        i_mem_busy = 1'b0;
      end
    end
  end

  // Pulse and ready monitor at mid-cycle
  always @(negedge clk) begin
    for (int c = 0; c < NUM_CH; c++) begin
      if (o_ing_finished[c]) fin_count[c]++;
      if (o_ing_ready[c]) ready_seen[c] = 1'b1;
    end
  end

  initial begin : watchdog
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Error: timeout after %0d cycles", cycle_count);
    $display("Simulation finished: FAIL");
    $finish;
  end

  task automatic stream_ingress(input int ch, input addr_t base, input int n);
    int    sent;
    int    cyc;
    data_t d;
    sent = 0;
    cyc  = 0;
    i_ing_addr[ch]   = base;
    i_ing_enable[ch] = 1'b1;
    while (sent < n && cyc < WAIT_LIMIT) begin
      i_ing_stb[ch] = 1'b0;
      if (o_ing_ready[ch]) begin
        d = rand_bits(32);
        i_ing_stb[ch]  = 1'b1;
        i_ing_data[ch] = d;
        exp_mem[base + addr_t'(4 * sent)] = d;
        sent++;
      end
      @(posedge clk);
      #1;
      cyc++;
    end
    i_ing_stb[ch]    = 1'b0;
    i_ing_enable[ch] = 1'b0;
    if (sent < n) report_error("ingress channel was not given ready in time");
  endtask

  task automatic stream_egress(input int ch, input addr_t base, input int n);
    int got;
    int cyc;
    int gap;
    got = 0;
    cyc = 0;
    gap = int'(rand_bits(2));
    i_egr_addr[ch]   = base;
    i_egr_enable[ch] = 1'b1;
    while (got < n && cyc < WAIT_LIMIT) begin
      i_egr_stb[ch] = 1'b0;
      if (o_egr_ready[ch]) begin
        if (gap == 0) begin
          check_value("o_egr_data", o_egr_data[ch], (base + addr_t'(4 * got)) ^ PATTERN);
          i_egr_stb[ch] = 1'b1;
          got++;
          // One block only
          i_egr_enable[ch] = 1'b0;
          gap = int'(rand_bits(2));
        end else begin
          gap--;
        end
      end
      @(posedge clk);
      #1;
      cyc++;
    end
    i_egr_stb[ch]    = 1'b0;
    i_egr_enable[ch] = 1'b0;
    if (got < n) report_error("egress channel delivered too few words");
    repeat (40) begin
      @(posedge clk);
      #1;
      if (o_egr_ready[ch]) report_error("egress ready high after the block ended");
    end
  endtask

  task automatic wait_finished(input int ch, input int target);
    int cyc;
    cyc = 0;
    while (fin_count[ch] < target && cyc < WAIT_LIMIT) begin
      @(posedge clk);
      #1;
      cyc++;
    end
    if (fin_count[ch] < target) report_error("ingress finished pulse missing");
    repeat (4) @(posedge clk);
    #1;
  endtask

  task automatic start_test();
    cmd_addr_q.delete();
    cmd_cnt_q.delete();
    cmd_wr_q.delete();
    for (int c = 0; c < NUM_CH; c++) begin
      fin_count[c]  = 0;
      ready_seen[c] = 1'b0;
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) $display("Test %s: ok", name);
    else $display("Test %s: %0d errors", name, errors - errs_before);
  endtask

  task automatic test_full_block();
    int e;
    e = errors;
    start_test();
    stream_ingress(0, 32'h1000, 16);
    wait_finished(0, 1);
    check_value("command count", 32'(cmd_addr_q.size()), 32'd1);
    check_command(0, 1'b1, 32'h1000, 16);
    check_stored(32'h1000, 16);
    end_test("full_block", e);
  endtask

  task automatic test_partial_block();
    int e;
    e = errors;
    start_test();
    stream_ingress(1, 32'h5000, 21);
    wait_finished(1, 1);
    check_value("command count", 32'(cmd_addr_q.size()), 32'd2);
    check_command(0, 1'b1, 32'h5000, 16);
    check_command(1, 1'b1, 32'h5040, 5);
    check_stored(32'h5000, 21);
    check_value("o_ing_finished[1] pulses", 32'(fin_count[1]), 32'd1);
    check_value("o_ing_ready[0] seen", 32'(ready_seen[0]), 32'd0);
    end_test("partial_block", e);
  endtask

  task automatic test_egress_stream();
    int e;
    e = errors;
    start_test();
    stream_egress(0, 32'h2000, 16);
    check_value("command count", 32'(cmd_addr_q.size()), 32'd1);
    check_command(0, 1'b0, 32'h2000, 16);
    end_test("egress_stream", e);
  endtask

  task automatic test_side_alternation();
    int e;
    e = errors;
    start_test();
    fork
      stream_ingress(1, 32'h6000, 16);
      stream_egress(0, 32'h7000, 16);
    join
    wait_finished(1, 1);
    check_value("command count", 32'(cmd_addr_q.size()), 32'd2);
    check_command(0, 1'b1, 32'h6000, 16);
    check_command(1, 1'b0, 32'h7000, 16);
    check_stored(32'h6000, 16);
    end_test("side_alternation", e);
  endtask

  // Second channel leaves a single word behind
  task automatic test_channel_alternation();
    int e;
    e = errors;
    start_test();
    fork
      stream_ingress(0, 32'h3000, 4);
      stream_ingress(1, 32'h4000, 1);
    join
    wait_finished(1, 1);
    check_value("o_ing_finished[0] pulses", 32'(fin_count[0]), 32'd1);
    check_value("command count", 32'(cmd_addr_q.size()), 32'd2);
    check_command(0, 1'b1, 32'h3000, 4);
    check_command(1, 1'b1, 32'h4000, 1);
    check_stored(32'h3000, 4);
    check_stored(32'h4000, 1);
    end_test("channel_alternation", e);
  endtask

  initial begin
    lfsr_state   = 32'he81a;
    errors       = 0;
    checks       = 0;
    tests_run    = 0;
    rst          = 1'b1;
    i_ing_enable = '0;
    i_ing_stb    = '0;
    i_egr_enable = '0;
    i_egr_stb    = '0;
    i_mem_busy   = 1'b0;
    i_buf_addr   = '0;
    i_buf_we     = 1'b0;
    i_buf_din    = '0;
    for (int c = 0; c < NUM_CH; c++) begin
      i_ing_addr[c] = '0;
      i_ing_data[c] = '0;
      i_egr_addr[c] = '0;
    end
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    // Side round-robin order makes ingress win first in the mixed test
    test_full_block();
    test_partial_block();
    test_egress_stream();
    test_side_alternation();
    test_channel_alternation();
    $display("Tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: vlog.f
dma_cfg_pkg.sv
seq_pkg.sv
dma_ifs.sv
dma_arbiter.sv
block_buffer.sv
transfer_sequencer.sv
ddr_arbiter_top.sv
tb_ddr_arbiter_assert.sv
tb_ddr_arbiter.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_ddr_arbiter \
  -f vlog.f -o sim_tb_ddr_arbiter
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb_ddr_arbiter)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
echo "$out" | grep -q "Simulation finished: PASS" || exit 1
exit 0
